// File: design/copy_config.svh
// Copy subsystem configuration macros
// Bus address and data widths, SRAM depth and the SRAM window base

`ifndef COPY_CONFIG_SVH
`define COPY_CONFIG_SVH

// Bus word address width
`define COPY_ADDR_W 32

// Data word width
`define COPY_DATA_W 32

// SRAM word index width, 1024 words
`define SRAM_ADDR_W 10

// Word address where the SRAM window starts, lower SRAM_ADDR_W bits zero
`define SRAM_BASE 32'h0004_0000

`endif

// File: design/copy_pkg.sv
// Shared types for the copy subsystem
// Engine FSM state encoding and bus response status

`default_nettype none

`include "copy_config.svh"

package copy_pkg;

    // Copy engine FSM states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        RD_REQ  = 3'd1,
        RD_WAIT = 3'd2,
        WR_REQ  = 3'd3,
        WR_WAIT = 3'd4,
        FINISH  = 3'd5
    } engine_state_e;

    // Bus response status
    typedef enum logic {
        OK     = 1'b0,
        DECERR = 1'b1
    } rsp_status_e;

endpackage

`default_nettype wire

// File: design/copy_engine.sv
// Word copy engine
// Reads each source word and writes it to the destination, one access
// in flight, stopping on the first decode error

`default_nettype none

`include "copy_config.svh"

module copy_engine (
    input  logic                      core_clk,
    input  logic                      rst_n,

    // Control
    input  logic                      start,
    input  logic [`COPY_ADDR_W-1:0]   src_addr,
    input  logic [`COPY_ADDR_W-1:0]   dst_addr,
    input  logic [15:0]               word_count,
    output logic                      busy,
    output logic                      done,
    output logic                      error,
    output logic [`COPY_ADDR_W-1:0]   err_addr,

    // Bus request
    output logic                      req_valid,
    input  logic                      req_ready,
    output logic                      req_write,
    output logic [`COPY_ADDR_W-1:0]   req_addr,
    output logic [`COPY_DATA_W-1:0]   req_wdata,

    // Bus response
    input  logic                      rsp_valid,
    input  logic [`COPY_DATA_W-1:0]   rsp_rdata,
    input  copy_pkg::rsp_status_e     rsp_status
);

    copy_pkg::engine_state_e state;

    logic [`COPY_ADDR_W-1:0] src_q;
    logic [`COPY_ADDR_W-1:0] dst_q;
    logic [15:0]             words_left;
    logic [`COPY_DATA_W-1:0] data_q;

    logic idle_start;
    logic req_fire;
    logic rsp_err;
    logic last_word;

    assign idle_start = start && (state == copy_pkg::IDLE);
    assign req_fire   = req_valid && req_ready;
    assign rsp_err    = rsp_valid && (rsp_status == copy_pkg::DECERR);
    assign last_word  = (words_left == 16'd1);

    // Request fields follow the current phase
    assign req_valid = (state == copy_pkg::RD_REQ) || (state == copy_pkg::WR_REQ);
    assign req_write = (state == copy_pkg::WR_REQ);
    assign req_addr  = req_write ? dst_q : src_q;
    assign req_wdata = data_q;

    // Control FSM
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            state <= copy_pkg::IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                copy_pkg::IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        error <= 1'b0;
                        // Zero count goes straight to completion
                        state <= (word_count == 16'd0) ? copy_pkg::FINISH
                                                       : copy_pkg::RD_REQ;
                    end
                end
                copy_pkg::RD_REQ: begin
                    if (req_fire) begin
                        state <= copy_pkg::RD_WAIT;
                    end
                end
                copy_pkg::RD_WAIT: begin
                    if (rsp_err) begin
                        error <= 1'b1;
                        state <= copy_pkg::FINISH;
                    end else if (rsp_valid) begin
                        state <= copy_pkg::WR_REQ;
                    end
                end
                copy_pkg::WR_REQ: begin
                    if (req_fire) begin
                        state <= copy_pkg::WR_WAIT;
                    end
                end
                copy_pkg::WR_WAIT: begin
                    if (rsp_err) begin
                        error <= 1'b1;
                        state <= copy_pkg::FINISH;
                    end else if (rsp_valid) begin
                        state <= last_word ? copy_pkg::FINISH : copy_pkg::RD_REQ;
                    end
                end
                copy_pkg::FINISH: begin
                    // busy drops as done pulses
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= copy_pkg::IDLE;
                end
                default: begin
                    state <= copy_pkg::IDLE;
                end
            endcase
        end
    end

    // Address, count and data registers
    always_ff @(posedge core_clk) begin
        if (idle_start) begin
            src_q      <= src_addr;
            dst_q      <= dst_addr;
            words_left <= word_count;
            err_addr   <= '0;
        end
        if ((state == copy_pkg::RD_WAIT) && rsp_valid) begin
            data_q <= rsp_rdata;
        end
        // Failing access address
        if ((state == copy_pkg::RD_WAIT) && rsp_err) begin
            err_addr <= src_q;
        end
        if ((state == copy_pkg::WR_WAIT) && rsp_err) begin
            err_addr <= dst_q;
        end
        // Advance to next word after a good write
        if ((state == copy_pkg::WR_WAIT) && rsp_valid && !rsp_err) begin
            src_q      <= src_q + 1'b1;
            dst_q      <= dst_q + 1'b1;
            words_left <= words_left - 1'b1;
        end
    end

    // Request held with the same fields until accepted
    req_hold_a: assert property (@(posedge core_clk) disable iff (!rst_n)
        req_valid && !req_ready |=>
            req_valid && $stable(req_write) && $stable(req_addr) && $stable(req_wdata));

    // Completion pulse never overlaps busy
    done_busy_a: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(done && busy));

    // Responses only while waiting on an accepted request
    rsp_phase_a: assert property (@(posedge core_clk) disable iff (!rst_n)
        rsp_valid |-> (state != copy_pkg::RD_REQ) && (state != copy_pkg::WR_REQ));

endmodule

`default_nettype wire

// File: design/sram_window_decode.sv
// Address window decoder
// Routes in-window requests to the SRAM with a truncated address and
// answers out-of-window requests with a decode error

`default_nettype none

`include "copy_config.svh"

module sram_window_decode (
    input  logic                      core_clk,
    input  logic                      rst_n,

    // Upstream bus from the engine
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_write,
    input  logic [`COPY_ADDR_W-1:0]   req_addr,
    input  logic [`COPY_DATA_W-1:0]   req_wdata,
    output logic                      rsp_valid,
    output logic [`COPY_DATA_W-1:0]   rsp_rdata,
    output copy_pkg::rsp_status_e     rsp_status,

    // Downstream bus to the SRAM
    output logic                      sram_req_valid,
    input  logic                      sram_req_ready,
    output logic                      sram_req_write,
    output logic [`SRAM_ADDR_W-1:0]   sram_req_addr,
    output logic [`COPY_DATA_W-1:0]   sram_req_wdata,
    input  logic                      sram_rsp_valid,
    input  logic [`COPY_DATA_W-1:0]   sram_rsp_rdata,
    input  copy_pkg::rsp_status_e     sram_rsp_status
);

    localparam logic [`COPY_ADDR_W-1:0] WIN_BASE = `SRAM_BASE;

    logic hit;
    logic err_pending;

    // Upper address bits select the window
    assign hit = (req_addr[`COPY_ADDR_W-1:`SRAM_ADDR_W] ==
                  WIN_BASE[`COPY_ADDR_W-1:`SRAM_ADDR_W]);

    assign sram_req_valid = req_valid && hit;
    assign sram_req_write = req_write;
    assign sram_req_addr  = req_addr[`SRAM_ADDR_W-1:0];
    assign sram_req_wdata = req_wdata;

    // Misses are always accepted
    assign req_ready = hit ? sram_req_ready : 1'b1;

    // One-cycle error responder
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            err_pending <= 1'b0;
        end else begin
            err_pending <= req_valid && !hit;
        end
    end

    assign rsp_valid  = sram_rsp_valid || err_pending;
    assign rsp_rdata  = err_pending ? '0 : sram_rsp_rdata;
    assign rsp_status = err_pending ? copy_pkg::DECERR : sram_rsp_status;

    // Only one responder per cycle
    rsp_excl_a: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(sram_rsp_valid && err_pending));

endmodule

`default_nettype wire

// File: design/bus_sram.sv
// Dual-port word SRAM
// Bus port with registered single-beat response, host port with
// priority and a registered read

`default_nettype none

`include "copy_config.svh"

module bus_sram (
    input  logic                      core_clk,
    input  logic                      rst_n,

    // Bus port
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_write,
    input  logic [`SRAM_ADDR_W-1:0]   req_addr,
    input  logic [`COPY_DATA_W-1:0]   req_wdata,
    output logic                      rsp_valid,
    output logic [`COPY_DATA_W-1:0]   rsp_rdata,
    output copy_pkg::rsp_status_e     rsp_status,

    // Host port
    input  logic                      host_en,
    input  logic                      host_write,
    input  logic [`SRAM_ADDR_W-1:0]   host_addr,
    input  logic [`COPY_DATA_W-1:0]   host_wdata,
    output logic [`COPY_DATA_W-1:0]   host_rdata
);

    localparam int DEPTH = 2 ** `SRAM_ADDR_W;

    logic [`COPY_DATA_W-1:0] mem [DEPTH];

    logic bus_fire;

    // Host owns the array whenever enabled
    assign req_ready = !host_en;
    assign bus_fire  = req_valid && req_ready;

    // In-window accesses never fail
    assign rsp_status = copy_pkg::OK;

    // Array access, one port per cycle
    always_ff @(posedge core_clk) begin
        if (host_en) begin
            if (host_write) begin
                mem[host_addr] <= host_wdata;
            end else begin
                host_rdata <= mem[host_addr];
            end
        end else if (bus_fire) begin
            if (req_write) begin
                mem[req_addr] <= req_wdata;
            end else begin
                rsp_rdata <= mem[req_addr];
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= bus_fire;
        end
    end

    // One access in flight, so each response is a single-cycle pulse
    rsp_pulse_a: assert property (@(posedge core_clk) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid);

endmodule

`default_nettype wire

// File: design/copy_subsys_top.sv
// Copy subsystem top level
// Copy engine, window decoder and dual-port SRAM

`default_nettype none

`include "copy_config.svh"

module copy_subsys_top (
    input  logic                      core_clk,
    input  logic                      rst_n,

    // Copy control
    input  logic                      start,
    input  logic [`COPY_ADDR_W-1:0]   src_addr,
    input  logic [`COPY_ADDR_W-1:0]   dst_addr,
    input  logic [15:0]               word_count,
    output logic                      busy,
    output logic                      done,
    output logic                      error,
    output logic [`COPY_ADDR_W-1:0]   err_addr,

    // Host access to the SRAM, address is a window offset
    input  logic                      host_en,
    input  logic                      host_write,
    input  logic [`COPY_ADDR_W-1:0]   host_addr,
    input  logic [`COPY_DATA_W-1:0]   host_wdata,
    output logic [`COPY_DATA_W-1:0]   host_rdata
);

    // Engine side bus
    logic                      req_valid;
    logic                      req_ready;
    logic                      req_write;
    logic [`COPY_ADDR_W-1:0]   req_addr;
    logic [`COPY_DATA_W-1:0]   req_wdata;
    logic                      rsp_valid;
    logic [`COPY_DATA_W-1:0]   rsp_rdata;
    copy_pkg::rsp_status_e     rsp_status;

    // SRAM side bus
    logic                      sram_req_valid;
    logic                      sram_req_ready;
    logic                      sram_req_write;
    logic [`SRAM_ADDR_W-1:0]   sram_req_addr;
    logic [`COPY_DATA_W-1:0]   sram_req_wdata;
    logic                      sram_rsp_valid;
    logic [`COPY_DATA_W-1:0]   sram_rsp_rdata;
    copy_pkg::rsp_status_e     sram_rsp_status;

    copy_engine copy_engine_i (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .start      (start),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .word_count (word_count),
        .busy       (busy),
        .done       (done),
        .error      (error),
        .err_addr   (err_addr),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_status (rsp_status)
    );

    sram_window_decode sram_window_decode_i (
        .core_clk        (core_clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_write       (req_write),
        .req_addr        (req_addr),
        .req_wdata       (req_wdata),
        .rsp_valid       (rsp_valid),
        .rsp_rdata       (rsp_rdata),
        .rsp_status      (rsp_status),
        .sram_req_valid  (sram_req_valid),
        .sram_req_ready  (sram_req_ready),
        .sram_req_write  (sram_req_write),
        .sram_req_addr   (sram_req_addr),
        .sram_req_wdata  (sram_req_wdata),
        .sram_rsp_valid  (sram_rsp_valid),
        .sram_rsp_rdata  (sram_rsp_rdata),
        .sram_rsp_status (sram_rsp_status)
    );

    bus_sram bus_sram_i (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .req_valid  (sram_req_valid),
        .req_ready  (sram_req_ready),
        .req_write  (sram_req_write),
        .req_addr   (sram_req_addr),
        .req_wdata  (sram_req_wdata),
        .rsp_valid  (sram_rsp_valid),
        .rsp_rdata  (sram_rsp_rdata),
        .rsp_status (sram_rsp_status),
        .host_en    (host_en),
        .host_write (host_write),
        .host_addr  (host_addr[`SRAM_ADDR_W-1:0]),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

endmodule

`default_nettype wire

// File: verif/copy_subsys_tb.sv
// Testbench for the copy subsystem
// Clock and reset, host preload and readback, copy scenarios checked
// against a reference memory model, concurrent checks, timeout and summary

`default_nettype none

`include "copy_config.svh"

module copy_subsys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 2 ** `SRAM_ADDR_W;
    localparam logic [`COPY_ADDR_W-1:0] BASE = `SRAM_BASE;

    logic                      core_clk;
    logic                      rst_n;
    logic                      start;
    logic [`COPY_ADDR_W-1:0]   src_addr;
    logic [`COPY_ADDR_W-1:0]   dst_addr;
    logic [15:0]               word_count;
    logic                      busy;
    logic                      done;
    logic                      error;
    logic [`COPY_ADDR_W-1:0]   err_addr;
    logic                      host_en;
    logic                      host_write;
    logic [`COPY_ADDR_W-1:0]   host_addr;
    logic [`COPY_DATA_W-1:0]   host_wdata;
    logic [`COPY_DATA_W-1:0]   host_rdata;

    // Reference memory and expected results
    logic [`COPY_DATA_W-1:0]   model [MEM_WORDS];
    logic                      exp_error;
    logic [`COPY_ADDR_W-1:0]   exp_err_addr;
    logic [`COPY_DATA_W-1:0]   exp_rdata;
    logic                      started;

    // Check pipelines, registered on the rising edge
    logic                      rd_chk_q;
    logic [`COPY_DATA_W-1:0]   exp_rdata_q;
    logic                      zero_d1;
    logic                      zero_d2;

    logic wait_active = 1'b0;
    int   wait_cycles = 0;
    int   cycle_limit = 500;
    int   errors = 0;
    int   copy_words;

    copy_subsys_top copy_subsys_top_i (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .start      (start),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .word_count (word_count),
        .busy       (busy),
        .done       (done),
        .error      (error),
        .err_addr   (err_addr),
        .host_en    (host_en),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    // Watchdog over the cycles spent waiting for copies
    always @(posedge core_clk) begin
        if (wait_active) begin
            wait_cycles <= wait_cycles + 1;
        end
        if (wait_cycles > cycle_limit) begin
            $display("Timeout: done did not arrive within %0d copy cycles", cycle_limit);
            $display("Summary: %0d words requested, %0d errors", copy_words, errors);
            $display("sim failed");
            $finish;
        end
    end

    // Host read lands in host_rdata at the edge that samples it
    always @(posedge core_clk) begin
        rd_chk_q    <= host_en && !host_write;
        exp_rdata_q <= exp_rdata;
        zero_d1     <= start && !busy && (word_count == 16'd0);
        zero_d2     <= zero_d1;
    end

    // Outputs are compared at the falling edge, away from any update
    quiet_before_start_a: assert property (@(negedge core_clk) disable iff (!rst_n)
        !started |-> !busy && !done && !error)
        else begin
            errors++;
            $display("Error %0d ns: busy/done/error expected 000 actual %b%b%b",
                     $time, busy, done, error);
        end

    error_hold_a: assert property (@(negedge core_clk) disable iff (!rst_n)
        started && !busy && !start |-> error == exp_error)
        else begin
            errors++;
            $display("Error %0d ns: error expected %b actual %b", $time, exp_error, error);
        end

    err_addr_a: assert property (@(negedge core_clk) disable iff (!rst_n)
        done && exp_error |-> err_addr == exp_err_addr)
        else begin
            errors++;
            $display("Error %0d ns: err_addr expected %08h actual %08h",
                     $time, exp_err_addr, err_addr);
        end

    done_alone_a: assert property (@(negedge core_clk) disable iff (!rst_n)
        done |-> !busy)
        else begin
            errors++;
            $display("Error %0d ns: busy expected 0 actual %b during done", $time, busy);
        end

    zero_count_a: assert property (@(negedge core_clk) disable iff (!rst_n)
        zero_d2 |-> done)
        else begin
            errors++;
            $display("Error %0d ns: done expected 1 actual %b two cycles after start",
                     $time, done);
        end

    readback_a: assert property (@(negedge core_clk) disable iff (!rst_n)
        rd_chk_q |-> host_rdata == exp_rdata_q)
        else begin
            errors++;
            $display("Error %0d ns: host_rdata expected %08h actual %08h",
                     $time, exp_rdata_q, host_rdata);
        end

    task automatic step();
        @(posedge core_clk);
        #1;
    endtask

    function automatic logic in_window(input logic [`COPY_ADDR_W-1:0] addr);
        return addr[`COPY_ADDR_W-1:`SRAM_ADDR_W] == BASE[`COPY_ADDR_W-1:`SRAM_ADDR_W];
    endfunction

    task automatic load_memory();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            host_en    = 1'b1;
            host_write = 1'b1;
            host_addr  = i;
            host_wdata = $urandom;
            model[i]   = host_wdata;
            step();
        end
        host_en = 1'b0;
    endtask

    task automatic compare_memory();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            host_en    = 1'b1;
            host_write = 1'b0;
            host_addr  = i;
            exp_rdata  = model[i];
            step();
        end
        host_en = 1'b0;
        step();
    endtask

    // Ascending word copy that stops at the first access outside the window
    task automatic predict_copy(input logic [`COPY_ADDR_W-1:0] src,
                                input logic [`COPY_ADDR_W-1:0] dst, input int count);
        logic [`COPY_ADDR_W-1:0] s;
        logic [`COPY_ADDR_W-1:0] d;
        int i;
        exp_error    = 1'b0;
        exp_err_addr = '0;
        i = 0;
        while ((i < count) && !exp_error) begin
            s = src + i;
            d = dst + i;
            if (!in_window(s)) begin
                exp_error    = 1'b1;
                exp_err_addr = s;
            end else if (!in_window(d)) begin
                exp_error    = 1'b1;
                exp_err_addr = d;
            end else begin
                model[d[`SRAM_ADDR_W-1:0]] = model[s[`SRAM_ADDR_W-1:0]];
            end
            i++;
        end
    endtask

    task automatic launch_copy(input logic [`COPY_ADDR_W-1:0] src,
                               input logic [`COPY_ADDR_W-1:0] dst, input int count);
        predict_copy(src, dst, count);
        src_addr   = src;
        dst_addr   = dst;
        word_count = count[15:0];
        start      = 1'b1;
        started    = 1'b1;
        step();
        start = 1'b0;
    endtask

    task automatic wait_for_done();
        wait_active = 1'b1;
        while (!done) begin
            step();
        end
        wait_active = 1'b0;
    endtask

    initial begin
        int len;
        int n;
        void'($urandom(32'h411166e5));
        rst_n        = 1'b0;
        start        = 1'b0;
        src_addr     = '0;
        dst_addr     = '0;
        word_count   = '0;
        host_en      = 1'b0;
        host_write   = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        exp_error    = 1'b0;
        exp_err_addr = '0;
        exp_rdata    = '0;
        started      = 1'b0;

        len         = 1 + ($urandom % 64);
        copy_words  = len + 4 + 6 + 32;
        cycle_limit = 8 * copy_words + 500;

        repeat (16) @(posedge core_clk);
        #1;
        rst_n = 1'b1;

        // Quiet outputs before any start
        repeat (8) step();
        load_memory();
        compare_memory();

        // In-window copy of random length
        launch_copy(BASE + 16, BASE + 200, len);
        wait_for_done();
        compare_memory();

        // Zero count
        launch_copy(BASE + 50, BASE + 500, 0);
        wait_for_done();
        compare_memory();

        // Source below the window
        launch_copy(BASE - 8, BASE + 600, 4);
        wait_for_done();
        compare_memory();

        // Destination runs past the top of the window
        launch_copy(BASE + 100, BASE + MEM_WORDS - 3, 6);
        wait_for_done();
        compare_memory();

        // Host traffic and a second start while the copy runs
        launch_copy(BASE + 300, BASE + 400, 32);
        n = 0;
        wait_active = 1'b1;
        while (!done) begin
            if (($urandom % 2) == 0) begin
                host_en    = 1'b1;
                host_write = 1'b1;
                host_addr  = 700 + ($urandom % 200);
                host_wdata = $urandom;
                model[host_addr[`SRAM_ADDR_W-1:0]] = host_wdata;
            end else begin
                host_en = 1'b0;
            end
            if (n == 5) begin
                start      = 1'b1;
                src_addr   = BASE - 100;
                word_count = 16'd5;
            end else begin
                start = 1'b0;
            end
            n++;
            step();
        end
        wait_active = 1'b0;
        host_en     = 1'b0;
        start       = 1'b0;
        repeat (4) step();
        compare_memory();

        repeat (4) step();
        $display("Summary: %0d words requested, %0d errors", copy_words, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/copy_pkg.sv
design/copy_engine.sv
design/sram_window_decode.sv
design/bus_sram.sv
design/copy_subsys_top.sv
verif/copy_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the copy subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module copy_subsys_tb -o copy_subsys_sim \
    && ./obj_dir/copy_subsys_sim | tee /dev/stderr | grep -q "sim passed" \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
